// ==== source/dma_bench_pkg.sv ====
////////////////////
// dma bench types
////////////////////
package dma_bench_pkg;

    typedef logic [15:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [63:0] dma_addr_t;
    typedef logic [13:0] ram_addr_t;
    typedef logic [15:0] dma_len_t;
    typedef logic [7:0]  dma_tag_t;
    typedef logic [3:0]  dma_err_t;

    // address bit selecting the block run page
    localparam int BLOCK_PAGE_BIT = 12;

    // control page
    localparam csr_addr_t REG_INT_EN    = 16'h0008;
    localparam csr_addr_t REG_ACTIVE    = 16'h0020;
    localparam csr_addr_t REG_RD_DMA_LO = 16'h0100;
    localparam csr_addr_t REG_RD_DMA_HI = 16'h0104;
    localparam csr_addr_t REG_RD_RAM    = 16'h0108;
    localparam csr_addr_t REG_RD_LEN    = 16'h0110;
    localparam csr_addr_t REG_RD_TAG    = 16'h0114;
    localparam csr_addr_t REG_RD_STATUS = 16'h0118;

    // block page offsets within the page
    localparam csr_addr_t REG_BLK_RUN        = 16'h0000;
    localparam csr_addr_t REG_BLK_CYC_LO     = 16'h0008;
    localparam csr_addr_t REG_BLK_CYC_HI     = 16'h000c;
    localparam csr_addr_t REG_BLK_LEN        = 16'h0010;
    localparam csr_addr_t REG_BLK_COUNT      = 16'h0018;
    localparam csr_addr_t REG_BLK_DMA_BASE   = 16'h0080;
    localparam csr_addr_t REG_BLK_DMA_OFS    = 16'h0088;
    localparam csr_addr_t REG_BLK_DMA_MASK   = 16'h0090;
    localparam csr_addr_t REG_BLK_DMA_STRIDE = 16'h0098;
    localparam csr_addr_t REG_BLK_RAM_BASE   = 16'h00c0;
    localparam csr_addr_t REG_BLK_RAM_OFS    = 16'h00c8;
    localparam csr_addr_t REG_BLK_RAM_MASK   = 16'h00d0;
    localparam csr_addr_t REG_BLK_RAM_STRIDE = 16'h00d8;

    // status word layout
    localparam int STATUS_TAG_LSB   = 0;
    localparam int STATUS_ERR_LSB   = 24;
    localparam int STATUS_VALID_BIT = 31;

endpackage

// ==== source/csr_if.sv ====
////////////////////
// register strobes
////////////////////
`timescale 1ns/1ns

interface csr_if;
    import dma_bench_pkg::*;

    logic      wr_en;
    csr_addr_t wr_addr;
    csr_data_t wr_data;
    logic      rd_en;
    csr_addr_t rd_addr;
    csr_data_t rd_data;

    modport initiator (
        output wr_en, wr_addr, wr_data, rd_en, rd_addr,
        input  rd_data
    );

    modport target (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
        output rd_data
    );
endinterface

// ==== source/desc_if.sv ====
////////////////////
// descriptor load
////////////////////
`timescale 1ns/1ns

interface desc_if;
    import dma_bench_pkg::*;

    logic      load;
    dma_addr_t dma_addr;
    ram_addr_t ram_addr;
    dma_len_t  len;
    dma_tag_t  tag;
    // output empty or draining this cycle
    logic      slot_free;

    modport source (
        output load, dma_addr, ram_addr, len, tag,
        input  slot_free
    );

    modport sink (
        input  load, dma_addr, ram_addr, len, tag,
        output slot_free
    );
endinterface

// ==== source/axil_reg_port.sv ====
////////////////////
// AXI-lite slave port
////////////////////
`timescale 1ns/1ns

module axil_reg_port (
    input  logic                     clk,
    input  logic                     rst,
    input  dma_bench_pkg::csr_addr_t awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  dma_bench_pkg::csr_data_t wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  dma_bench_pkg::csr_addr_t araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output dma_bench_pkg::csr_data_t rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    csr_if.initiator                 csr
);

    // one write per beat with address and data together
    assign csr.wr_en   = awvalid && wvalid && !bvalid;
    assign csr.wr_addr = {awaddr[15:2], 2'b00};
    assign csr.wr_data = wdata;

    assign csr.rd_en   = arvalid && !rvalid;
    assign csr.rd_addr = {araddr[15:2], 2'b00};

    // every access answers OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_ff @(posedge clk) begin
        awready <= csr.wr_en;
        wready  <= csr.wr_en;
        bvalid  <= csr.wr_en || (bvalid && !bready);

        arready <= csr.rd_en;
        rvalid  <= csr.rd_en || (rvalid && !rready);

        if (csr.rd_en) begin
            rdata <= csr.rd_data;
        end

        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
    end

endmodule

// ==== source/dma_csr.sv ====
////////////////////
// control registers
////////////////////
`timescale 1ns/1ns

module dma_csr #(
    parameter int ACTIVE_WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    csr_if.target                   csr,
    csr_if.initiator                blk,
    desc_if.source                  single,
    input  dma_bench_pkg::dma_tag_t status_tag,
    input  dma_bench_pkg::dma_err_t status_error,
    input  logic                    status_valid,
    input  logic [ACTIVE_WIDTH-1:0] active_count,
    output logic                    irq
);
    import dma_bench_pkg::*;

    localparam csr_addr_t PAGE_MASK = csr_addr_t'((1 << BLOCK_PAGE_BIT) - 1);

    logic      ctl_wr;
    logic      ctl_rd;
    logic      int_en;
    logic      launch;
    dma_addr_t sd_dma_addr;
    ram_addr_t sd_ram_addr;
    dma_len_t  sd_len;
    dma_tag_t  sd_tag;
    dma_tag_t  st_tag;
    dma_err_t  st_err;
    logic      st_valid;

    // page decode
    assign ctl_wr = csr.wr_en && !csr.wr_addr[BLOCK_PAGE_BIT];
    assign ctl_rd = csr.rd_en && !csr.rd_addr[BLOCK_PAGE_BIT];

    assign blk.wr_en   = csr.wr_en && csr.wr_addr[BLOCK_PAGE_BIT];
    assign blk.wr_addr = csr.wr_addr & PAGE_MASK;
    assign blk.wr_data = csr.wr_data;
    assign blk.rd_en   = csr.rd_en && csr.rd_addr[BLOCK_PAGE_BIT];
    assign blk.rd_addr = csr.rd_addr & PAGE_MASK;

    assign single.load     = launch;
    assign single.dma_addr = sd_dma_addr;
    assign single.ram_addr = sd_ram_addr;
    assign single.len      = sd_len;
    assign single.tag      = sd_tag;

    assign irq = status_valid && int_en;

    always_ff @(posedge clk) begin
        launch <= 1'b0;
        if (ctl_wr) begin
            case (csr.wr_addr)
                REG_INT_EN:    int_en <= csr.wr_data[0];
                REG_RD_DMA_LO: sd_dma_addr[31:0] <= csr.wr_data;
                REG_RD_DMA_HI: sd_dma_addr[63:32] <= csr.wr_data;
                REG_RD_RAM:    sd_ram_addr <= ram_addr_t'(csr.wr_data);
                REG_RD_LEN:    sd_len <= dma_len_t'(csr.wr_data);
                REG_RD_TAG: begin
                    sd_tag <= dma_tag_t'(csr.wr_data);
                    launch <= 1'b1;
                end
                default: ;
            endcase
        end

        // a new strobe beats the read clear on the same edge
        if (ctl_rd && csr.rd_addr == REG_RD_STATUS) begin
            st_valid <= 1'b0;
        end
        if (status_valid) begin
            st_tag   <= status_tag;
            st_err   <= status_error;
            st_valid <= 1'b1;
        end

        if (rst) begin
            int_en   <= 1'b0;
            launch   <= 1'b0;
            st_valid <= 1'b0;
        end
    end

    always_comb begin
        csr.rd_data = '0;
        if (csr.rd_addr[BLOCK_PAGE_BIT]) begin
            csr.rd_data = blk.rd_data;
        end else begin
            case (csr.rd_addr)
                REG_INT_EN:    csr.rd_data[0] = int_en;
                REG_ACTIVE:    csr.rd_data = csr_data_t'(active_count);
                REG_RD_DMA_LO: csr.rd_data = sd_dma_addr[31:0];
                REG_RD_DMA_HI: csr.rd_data = sd_dma_addr[63:32];
                REG_RD_RAM:    csr.rd_data = csr_data_t'(sd_ram_addr);
                REG_RD_LEN:    csr.rd_data = csr_data_t'(sd_len);
                REG_RD_TAG:    csr.rd_data = csr_data_t'(sd_tag);
                REG_RD_STATUS: begin
                    csr.rd_data[STATUS_TAG_LSB +: 16] = 16'(st_tag);
                    csr.rd_data[STATUS_ERR_LSB +: 4]  = st_err;
                    csr.rd_data[STATUS_VALID_BIT]     = st_valid;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== source/block_desc_gen.sv ====
////////////////////
// block run generator
////////////////////
`timescale 1ns/1ns

module block_desc_gen (
    input  logic   clk,
    input  logic   rst,
    csr_if.target  csr,
    desc_if.source desc,
    input  logic   inflight_none
);
    import dma_bench_pkg::*;

    logic        run;
    logic [63:0] cyc_count;
    dma_len_t    blk_len;
    csr_data_t   count;
    dma_addr_t   dma_base;
    dma_addr_t   dma_ofs;
    dma_addr_t   dma_mask;
    dma_addr_t   dma_stride;
    ram_addr_t   ram_base;
    ram_addr_t   ram_ofs;
    ram_addr_t   ram_mask;
    ram_addr_t   ram_stride;

    // next descriptor of the series
    assign desc.load     = run && count != '0 && desc.slot_free;
    assign desc.dma_addr = dma_base + (dma_ofs & dma_mask);
    assign desc.ram_addr = ram_base + (ram_ofs & ram_mask);
    assign desc.len      = blk_len;
    assign desc.tag      = dma_tag_t'(count);

    always_ff @(posedge clk) begin
        if (csr.wr_en) begin
            case (csr.wr_addr)
                REG_BLK_RUN:                 run <= csr.wr_data[0];
                REG_BLK_CYC_LO:              cyc_count[31:0] <= csr.wr_data;
                REG_BLK_CYC_HI:              cyc_count[63:32] <= csr.wr_data;
                REG_BLK_LEN:                 blk_len <= dma_len_t'(csr.wr_data);
                REG_BLK_COUNT:               count <= csr.wr_data;
                REG_BLK_DMA_BASE:            dma_base[31:0] <= csr.wr_data;
                REG_BLK_DMA_BASE + 16'h4:    dma_base[63:32] <= csr.wr_data;
                REG_BLK_DMA_OFS:             dma_ofs[31:0] <= csr.wr_data;
                REG_BLK_DMA_OFS + 16'h4:     dma_ofs[63:32] <= csr.wr_data;
                REG_BLK_DMA_MASK:            dma_mask[31:0] <= csr.wr_data;
                REG_BLK_DMA_MASK + 16'h4:    dma_mask[63:32] <= csr.wr_data;
                REG_BLK_DMA_STRIDE:          dma_stride[31:0] <= csr.wr_data;
                REG_BLK_DMA_STRIDE + 16'h4:  dma_stride[63:32] <= csr.wr_data;
                REG_BLK_RAM_BASE:            ram_base <= ram_addr_t'(csr.wr_data);
                REG_BLK_RAM_OFS:             ram_ofs <= ram_addr_t'(csr.wr_data);
                REG_BLK_RAM_MASK:            ram_mask <= ram_addr_t'(csr.wr_data);
                REG_BLK_RAM_STRIDE:          ram_stride <= ram_addr_t'(csr.wr_data);
                default: ;
            endcase
        end

        // run activity overrides a register write on the same edge
        if (run) begin
            cyc_count <= cyc_count + 64'd1;
            if (count == '0 && inflight_none) begin
                run <= 1'b0;
            end
        end
        if (desc.load) begin
            dma_ofs <= dma_ofs + dma_stride;
            ram_ofs <= ram_ofs + ram_stride;
            count   <= count - 1'b1;
        end

        if (rst) begin
            run <= 1'b0;
        end
    end

    always_comb begin
        csr.rd_data = '0;
        case (csr.rd_addr)
            REG_BLK_RUN:                csr.rd_data[0] = run;
            REG_BLK_CYC_LO:             csr.rd_data = cyc_count[31:0];
            REG_BLK_CYC_HI:             csr.rd_data = cyc_count[63:32];
            REG_BLK_LEN:                csr.rd_data = csr_data_t'(blk_len);
            REG_BLK_COUNT:              csr.rd_data = count;
            REG_BLK_DMA_BASE:           csr.rd_data = dma_base[31:0];
            REG_BLK_DMA_BASE + 16'h4:   csr.rd_data = dma_base[63:32];
            REG_BLK_DMA_OFS:            csr.rd_data = dma_ofs[31:0];
            REG_BLK_DMA_OFS + 16'h4:    csr.rd_data = dma_ofs[63:32];
            REG_BLK_DMA_MASK:           csr.rd_data = dma_mask[31:0];
            REG_BLK_DMA_MASK + 16'h4:   csr.rd_data = dma_mask[63:32];
            REG_BLK_DMA_STRIDE:         csr.rd_data = dma_stride[31:0];
            REG_BLK_DMA_STRIDE + 16'h4: csr.rd_data = dma_stride[63:32];
            REG_BLK_RAM_BASE:           csr.rd_data = csr_data_t'(ram_base);
            REG_BLK_RAM_OFS:            csr.rd_data = csr_data_t'(ram_ofs);
            REG_BLK_RAM_MASK:           csr.rd_data = csr_data_t'(ram_mask);
            REG_BLK_RAM_STRIDE:         csr.rd_data = csr_data_t'(ram_stride);
            default: ;
        endcase
    end

endmodule

// ==== source/desc_out.sv ====
////////////////////
// descriptor output
////////////////////
`timescale 1ns/1ns

module desc_out #(
    parameter int ACTIVE_WIDTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    desc_if.sink                     single,
    desc_if.sink                     block,
    output dma_bench_pkg::dma_addr_t dma_addr,
    output dma_bench_pkg::ram_addr_t ram_addr,
    output dma_bench_pkg::dma_len_t  len,
    output dma_bench_pkg::dma_tag_t  tag,
    output logic                     valid,
    input  logic                     ready,
    input  logic                     status_valid,
    output logic [ACTIVE_WIDTH-1:0]  active_count,
    output logic                     inflight_none
);

    logic accept;
    logic slot_free;

    assign accept    = valid && ready;
    assign slot_free = !valid || ready;

    assign single.slot_free = slot_free;
    assign block.slot_free  = slot_free;

    // a descriptor still held here counts as in flight too
    assign inflight_none = active_count == '0 && !valid;

    always_ff @(posedge clk) begin
        valid <= valid && !ready;

        // block source wins a same-cycle load
        if (block.load) begin
            dma_addr <= block.dma_addr;
            ram_addr <= block.ram_addr;
            len      <= block.len;
            tag      <= block.tag;
            valid    <= 1'b1;
        end else if (single.load) begin
            dma_addr <= single.dma_addr;
            ram_addr <= single.ram_addr;
            len      <= single.len;
            tag      <= single.tag;
            valid    <= 1'b1;
        end

        active_count <= active_count + ACTIVE_WIDTH'(accept) - ACTIVE_WIDTH'(status_valid);

        if (rst) begin
            valid        <= 1'b0;
            active_count <= '0;
        end
    end

endmodule

// ==== source/dma_bench.sv ====
////////////////////
// DMA bench top
////////////////////
`timescale 1ns/1ns

module dma_bench #(
    parameter int ACTIVE_WIDTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  dma_bench_pkg::csr_addr_t awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  dma_bench_pkg::csr_data_t wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  dma_bench_pkg::csr_addr_t araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output dma_bench_pkg::csr_data_t rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output dma_bench_pkg::dma_addr_t desc_dma_addr,
    output dma_bench_pkg::ram_addr_t desc_ram_addr,
    output dma_bench_pkg::dma_len_t  desc_len,
    output dma_bench_pkg::dma_tag_t  desc_tag,
    output logic                     desc_valid,
    input  logic                     desc_ready,
    input  dma_bench_pkg::dma_tag_t  status_tag,
    input  dma_bench_pkg::dma_err_t  status_error,
    input  logic                     status_valid,
    output logic                     irq
);

    logic [ACTIVE_WIDTH-1:0] active_count;
    logic                    inflight_none;

    csr_if  bus_csr ();
    csr_if  blk_csr ();
    desc_if single_desc ();
    desc_if block_desc ();

    axil_reg_port u_axil_reg_port (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .csr(bus_csr.initiator)
    );

    dma_csr #(.ACTIVE_WIDTH(ACTIVE_WIDTH)) u_dma_csr (
        .clk(clk), .rst(rst),
        .csr(bus_csr.target),
        .blk(blk_csr.initiator),
        .single(single_desc.source),
        .status_tag(status_tag), .status_error(status_error),
        .status_valid(status_valid),
        .active_count(active_count),
        .irq(irq)
    );

    block_desc_gen u_block_desc_gen (
        .clk(clk), .rst(rst),
        .csr(blk_csr.target),
        .desc(block_desc.source),
        .inflight_none(inflight_none)
    );

    desc_out #(.ACTIVE_WIDTH(ACTIVE_WIDTH)) u_desc_out (
        .clk(clk), .rst(rst),
        .single(single_desc.sink),
        .block(block_desc.sink),
        .dma_addr(desc_dma_addr), .ram_addr(desc_ram_addr),
        .len(desc_len), .tag(desc_tag),
        .valid(desc_valid), .ready(desc_ready),
        .status_valid(status_valid),
        .active_count(active_count),
        .inflight_none(inflight_none)
    );

endmodule

// ==== verif/dma_bench_tb.sv ====
////////////////////
// DMA bench testbench
////////////////////
`timescale 1ns/1ns

module dma_bench_tb;
    import dma_bench_pkg::*;

    typedef struct packed {
        dma_addr_t dma_addr;
        ram_addr_t ram_addr;
        dma_len_t  len;
        dma_tag_t  tag;
    } desc_t;

    localparam int        TIMEOUT   = 2000;
    localparam int        BLK_COUNT = 40;
    localparam csr_addr_t BLK_PAGE  = 16'h1000;

    logic      clk;
    logic      rst;
    csr_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    csr_data_t wdata;
    logic      wvalid;
    logic      wready;
    logic [1:0] bresp;
    logic      bvalid;
    logic      bready;
    csr_addr_t araddr;
    logic      arvalid;
    logic      arready;
    csr_data_t rdata;
    logic [1:0] rresp;
    logic      rvalid;
    logic      rready;
    dma_addr_t desc_dma_addr;
    ram_addr_t desc_ram_addr;
    dma_len_t  desc_len;
    dma_tag_t  desc_tag;
    logic      desc_valid;
    logic      desc_ready;
    dma_tag_t  status_tag;
    dma_err_t  status_error;
    logic      status_valid;
    logic      irq;

    int        mismatches;
    int        timeouts;
    int        accepted;
    int        irq_pulses;
    logic      int_en_exp;
    desc_t     exp_q[$];
    dma_tag_t  pend_q[$];
    desc_t     exp_desc;
    dma_tag_t  last_tag;
    dma_err_t  last_err;

    // programmed values mirrored for the reference
    dma_addr_t sd_dma_addr;
    ram_addr_t sd_ram_addr;
    dma_len_t  sd_len;
    dma_addr_t blk_dma_base;
    dma_addr_t blk_dma_mask;
    dma_addr_t blk_dma_stride;
    ram_addr_t blk_ram_base;
    ram_addr_t blk_ram_mask;
    ram_addr_t blk_ram_stride;
    dma_len_t  blk_len;

    dma_bench #(.ACTIVE_WIDTH(16)) u_dut (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(4'hf), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .desc_dma_addr(desc_dma_addr), .desc_ram_addr(desc_ram_addr),
        .desc_len(desc_len), .desc_tag(desc_tag),
        .desc_valid(desc_valid), .desc_ready(desc_ready),
        .status_tag(status_tag), .status_error(status_error),
        .status_valid(status_valid), .irq(irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected descriptor k of a block run from zero start offsets
    function automatic desc_t block_ref(int k);
        desc_t d;
        d.dma_addr = blk_dma_base + ((dma_addr_t'(k) * blk_dma_stride) & blk_dma_mask);
        d.ram_addr = blk_ram_base + ((ram_addr_t'(k) * blk_ram_stride) & blk_ram_mask);
        d.len      = blk_len;
        d.tag      = dma_tag_t'(BLK_COUNT - k);
        return d;
    endfunction

    function automatic csr_data_t status_word(logic valid, dma_tag_t tag, dma_err_t err);
        return {valid, 3'b000, err, 8'h00, 8'h00, tag};
    endfunction

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        assert (expected == actual) else begin
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic axil_write(csr_addr_t addr, csr_data_t data);
        int cycles;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cycles  = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!bvalid && cycles < TIMEOUT);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        assert (bvalid) else begin
            $display("write to %h got no response", addr);
            timeouts++;
        end
        // ready pulses together with the response
        check_value("awready", 1, awready);
        check_value("wready", 1, wready);
        check_value("bresp", 0, bresp);
        @(posedge clk);
        #1;
        check_value("awready pulse", 0, awready);
        check_value("wready pulse", 0, wready);
    endtask

    task automatic axil_read(csr_addr_t addr, output csr_data_t data);
        int cycles;
        araddr  = addr;
        arvalid = 1'b1;
        cycles  = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!rvalid && cycles < TIMEOUT);
        arvalid = 1'b0;
        data    = rdata;
        assert (rvalid) else begin
            $display("read from %h got no response", addr);
            timeouts++;
        end
        check_value("arready", 1, arready);
        check_value("rresp", 0, rresp);
        @(posedge clk);
        #1;
        check_value("arready pulse", 0, arready);
    endtask

    task automatic read_check(string name, csr_addr_t addr, csr_data_t expected);
        csr_data_t value;
        axil_read(addr, value);
        check_value(name, expected, value);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || pend_q.size() != 0 || desc_valid) && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (exp_q.size() == 0 && pend_q.size() == 0) else begin
            $display("descriptors or status still outstanding after %0d cycles", cycles);
            timeouts++;
        end
        // let the last status strobe land
        @(posedge clk);
        #1;
    endtask

    task automatic set_int_en(logic en);
        axil_write(REG_INT_EN, {31'b0, en});
        int_en_exp = en;
        read_check("int enable", REG_INT_EN, {31'b0, en});
    endtask

    task automatic launch_single(dma_tag_t tag);
        desc_t d;
        int    base;
        d.dma_addr = sd_dma_addr;
        d.ram_addr = sd_ram_addr;
        d.len      = sd_len;
        d.tag      = tag;
        exp_q.push_back(d);
        base = accepted;
        axil_write(REG_RD_TAG, {24'b0, tag});
        wait_drain();
        check_value("single count", 1, accepted - base);
    endtask

    // DMA engine model with random ready and delayed status per descriptor
    initial begin
        int status_wait;
        status_wait  = 0;
        desc_ready   = 1'b0;
        status_valid = 1'b0;
        status_tag   = '0;
        status_error = '0;
        forever begin
            @(posedge clk);
            #1;
            desc_ready   = ($urandom_range(0, 3) != 0);
            status_valid = 1'b0;
            if (pend_q.size() != 0) begin
                if (status_wait == 0) begin
                    status_tag   = pend_q.pop_front();
                    status_error = dma_err_t'($urandom_range(0, 15));
                    status_valid = 1'b1;
                    last_tag     = status_tag;
                    last_err     = status_error;
                    status_wait  = $urandom_range(0, 6);
                end else begin
                    status_wait--;
                end
            end
        end
    end

    // compare on every accepted descriptor
    always @(negedge clk) begin
        if (!rst) begin
            check_value("irq", status_valid && int_en_exp, irq);
            if (irq) begin
                irq_pulses++;
            end
            if (desc_valid && desc_ready) begin
                accepted++;
                pend_q.push_back(desc_tag);
                assert (exp_q.size() != 0) else begin
                    $display("unexpected descriptor with tag %0h", desc_tag);
                    mismatches++;
                end
                if (exp_q.size() != 0) begin
                    exp_desc = exp_q.pop_front();
                    check_value("desc dma_addr", exp_desc.dma_addr, desc_dma_addr);
                    check_value("desc ram_addr", exp_desc.ram_addr, desc_ram_addr);
                    check_value("desc len", exp_desc.len, desc_len);
                    check_value("desc tag", exp_desc.tag, desc_tag);
                end
            end
        end
    end

    initial begin
        repeat (100000) @(posedge clk);
        $display("simulation did not finish within 100000 cycles");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        csr_data_t rd;
        int        base;
        int        cycles;
        void'($urandom(82463));
        mismatches = 0;
        timeouts   = 0;
        accepted   = 0;
        irq_pulses = 0;
        int_en_exp = 1'b0;
        rst        = 1'b1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b1;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // register read-back
        set_int_en(1'b1);
        set_int_en(1'b0);
        sd_dma_addr = {32'($urandom()), 32'($urandom())};
        sd_ram_addr = ram_addr_t'($urandom_range(0, 16383));
        sd_len      = dma_len_t'($urandom_range(1, 65535));
        axil_write(REG_RD_DMA_LO, sd_dma_addr[31:0]);
        axil_write(REG_RD_DMA_HI, sd_dma_addr[63:32]);
        axil_write(REG_RD_RAM, {18'b0, sd_ram_addr});
        axil_write(REG_RD_LEN, {16'b0, sd_len});
        read_check("dma lo", REG_RD_DMA_LO, sd_dma_addr[31:0]);
        read_check("dma hi", REG_RD_DMA_HI, sd_dma_addr[63:32]);
        read_check("ram addr", REG_RD_RAM, {18'b0, sd_ram_addr});
        read_check("length", REG_RD_LEN, {16'b0, sd_len});

        // single launch with irq off, then status with irq on
        launch_single(8'h5a);
        check_value("irq while disabled", 0, irq_pulses);
        set_int_en(1'b1);
        launch_single(8'hc3);
        check_value("irq pulses", 1, irq_pulses);
        read_check("status", REG_RD_STATUS, status_word(1'b1, last_tag, last_err));
        read_check("status cleared", REG_RD_STATUS, status_word(1'b0, last_tag, last_err));

        // block run
        blk_len        = 16'h0200;
        blk_dma_base   = {32'($urandom()), 32'($urandom()) & 32'hffff_0000};
        blk_dma_mask   = 64'h0000_0000_0000_3fff;
        blk_dma_stride = 64'h0000_0000_0000_0300;
        blk_ram_base   = 14'h1000;
        blk_ram_mask   = 14'h0fff;
        blk_ram_stride = 14'h0180;
        axil_write(BLK_PAGE | REG_BLK_LEN, {16'b0, blk_len});
        axil_write(BLK_PAGE | REG_BLK_COUNT, BLK_COUNT);
        axil_write(BLK_PAGE | REG_BLK_DMA_BASE, blk_dma_base[31:0]);
        axil_write(BLK_PAGE | (REG_BLK_DMA_BASE + 16'h4), blk_dma_base[63:32]);
        axil_write(BLK_PAGE | REG_BLK_DMA_OFS, 32'h0);
        axil_write(BLK_PAGE | (REG_BLK_DMA_OFS + 16'h4), 32'h0);
        axil_write(BLK_PAGE | REG_BLK_DMA_MASK, blk_dma_mask[31:0]);
        axil_write(BLK_PAGE | (REG_BLK_DMA_MASK + 16'h4), blk_dma_mask[63:32]);
        axil_write(BLK_PAGE | REG_BLK_DMA_STRIDE, blk_dma_stride[31:0]);
        axil_write(BLK_PAGE | (REG_BLK_DMA_STRIDE + 16'h4), blk_dma_stride[63:32]);
        axil_write(BLK_PAGE | REG_BLK_RAM_BASE, {18'b0, blk_ram_base});
        axil_write(BLK_PAGE | REG_BLK_RAM_OFS, 32'h0);
        axil_write(BLK_PAGE | REG_BLK_RAM_MASK, {18'b0, blk_ram_mask});
        axil_write(BLK_PAGE | REG_BLK_RAM_STRIDE, {18'b0, blk_ram_stride});
        axil_write(BLK_PAGE | REG_BLK_CYC_LO, 32'h0);
        axil_write(BLK_PAGE | REG_BLK_CYC_HI, 32'h0);
        for (int k = 0; k < BLK_COUNT; k++) begin
            exp_q.push_back(block_ref(k));
        end
        base = accepted;
        axil_write(BLK_PAGE | REG_BLK_RUN, 32'h1);

        // poll until run drops
        cycles = 0;
        do begin
            axil_read(BLK_PAGE | REG_BLK_RUN, rd);
            cycles++;
        end while (rd[0] && cycles < TIMEOUT);
        assert (!rd[0]) else begin
            $display("block run never finished");
            timeouts++;
        end
        wait_drain();
        check_value("block count", BLK_COUNT, accepted - base);
        read_check("active count", REG_ACTIVE, 32'h0);
        read_check("remaining count", BLK_PAGE | REG_BLK_COUNT, 32'h0);
        axil_read(BLK_PAGE | REG_BLK_CYC_LO, rd);
        assert (rd >= BLK_COUNT) else begin
            $display("Mismatch block cycles: expected at least %0d, actual %0d", BLK_COUNT, rd);
            mismatches++;
        end

        $display("mismatches %0d, timeouts %0d, descriptors %0d", mismatches, timeouts, accepted);
        if (mismatches == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
source/dma_bench_pkg.sv
source/csr_if.sv
source/desc_if.sv
source/axil_reg_port.sv
source/dma_csr.sv
source/block_desc_gen.sv
source/desc_out.sv
source/dma_bench.sv
verif/dma_bench_tb.sv

// ==== Makefile ====
TOP = dma_bench_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf obj_dir
